// File: design/csi2_pkg.sv
`default_nettype none

package csi2_pkg;

  localparam int NUM_LANES      = 2;
  localparam int MAX_LANE_DELAY = 3;

  // D-PHY leader sync byte
  localparam logic [7:0] SYNC_BYTE = 8'hB8;

  localparam logic [5:0] DT_FRAME_START = 6'h00;
  localparam logic [5:0] DT_FRAME_END   = 6'h01;
  localparam logic [5:0] DT_LONG_MIN    = 6'h10;

  // Hamming masks over header bits 23:0, entry i gives ECC bit i
  localparam logic [5:0][23:0] ECC_MASK = {
    24'hEFFC00,
    24'hDF03F0,
    24'hB8E38E,
    24'h749A6D,
    24'hF2555B,
    24'hF12CB7
  };

  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  // Packet decoder states
  localparam logic [1:0] ST_HEADER  = 2'd0;
  localparam logic [1:0] ST_PAYLOAD = 2'd1;
  localparam logic [1:0] ST_CRC     = 2'd2;
  localparam logic [1:0] ST_DISCARD = 2'd3;

  // Byte 0 is DI, bytes 1..2 are WC low first, byte 3 is ECC
  typedef union packed {
    struct packed {
      logic [7:0]  ecc;
      logic [23:0] data;
    } raw;
    struct packed {
      logic [7:0]  ecc;
      logic [15:0] wc;
      logic [1:0]  vc;
      logic [5:0]  dt;
    } fields;
  } csi2_header_u;

endpackage

`default_nettype wire

// File: design/csi2_lane_deskew.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_lane_deskew import csi2_pkg::*; (
  input  logic                           px_clk_i,
  input  logic                           rst_n_i,
  input  logic [NUM_LANES-1:0][7:0]      lane_byte_i,
  input  logic [NUM_LANES-1:0]           lane_valid_i,
  input  logic [NUM_LANES-1:0][1:0]      lane_delay_i,
  output logic [NUM_LANES-1:0][7:0]      dsk_byte_o,
  output logic [NUM_LANES-1:0]           dsk_valid_o
);

  logic [NUM_LANES-1:0][MAX_LANE_DELAY-1:0][7:0] byte_sr;
  logic [NUM_LANES-1:0][MAX_LANE_DELAY-1:0]      valid_sr;

  always_ff @(posedge px_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_sr <= '0;
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        valid_sr[l] <= {valid_sr[l][MAX_LANE_DELAY-2:0], lane_valid_i[l]};
      end
    end
  end

  always_ff @(posedge px_clk_i) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      byte_sr[l] <= {byte_sr[l][MAX_LANE_DELAY-2:0], lane_byte_i[l]};
    end
  end

  // Tap select, zero delay bypasses the shift register
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      if (lane_delay_i[l] == 2'd0) begin
        dsk_byte_o[l]  = lane_byte_i[l];
        dsk_valid_o[l] = lane_valid_i[l];
      end else begin
        dsk_byte_o[l]  = byte_sr[l][lane_delay_i[l] - 2'd1];
        dsk_valid_o[l] = valid_sr[l][lane_delay_i[l] - 2'd1];
      end
    end
  end

endmodule

`default_nettype wire

// File: design/csi2_lane_aligner.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_lane_aligner import csi2_pkg::*; (
  input  logic       px_clk_i,
  input  logic       rst_n_i,
  input  logic [7:0] byte_i,
  input  logic       valid_i,
  output logic [7:0] byte_o,
  output logic       valid_o,
  output logic       locked_o
);

  logic [7:0]  prev_q;
  logic        valid_q;
  logic        locked_q;
  logic [2:0]  offset_q;
  logic [15:0] window;
  logic        hit;
  logic [2:0]  hit_off;
  logic        emit;

  // Bits arrive LSB first, so the older byte sits in the low half
  assign window = {byte_i, prev_q};

  always_comb begin
    hit     = 1'b0;
    hit_off = 3'd0;
    for (int o = 7; o >= 0; o--) begin
      if (window[o +: 8] == SYNC_BYTE) begin
        hit     = 1'b1;
        hit_off = 3'(o);
      end
    end
  end

  // With offset 0 the last byte is still whole in prev_q when valid falls
  assign emit = locked_q && (valid_i || (valid_q && offset_q == 3'd0));

  always_ff @(posedge px_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prev_q   <= '0;
      valid_q  <= 1'b0;
      locked_q <= 1'b0;
      offset_q <= '0;
      valid_o  <= 1'b0;
    end else begin
      prev_q  <= valid_i ? byte_i : 8'h00;
      valid_q <= valid_i;
      valid_o <= emit;
      if (!locked_q) begin
        if (valid_i && hit) begin
          locked_q <= 1'b1;
          offset_q <= hit_off;
        end
      end else if (!valid_i && !valid_q) begin
        // Held one extra cycle so the flushed byte still leaves locked
        locked_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge px_clk_i) begin
    if (emit) begin
      byte_o <= window[offset_q +: 8];
    end
  end

  assign locked_o = locked_q;

  a_valid_locked : assert property (
    @(posedge px_clk_i) disable iff (!rst_n_i) valid_o |-> locked_o
  );

endmodule

`default_nettype wire

// File: design/csi2_lane_merge.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_lane_merge import csi2_pkg::*; (
  input  logic                      px_clk_i,
  input  logic                      rst_n_i,
  input  logic [NUM_LANES-1:0][7:0] al_byte_i,
  input  logic [NUM_LANES-1:0]      al_valid_i,
  output logic [15:0]               word_o,
  output logic                      valid_o,
  output logic                      eob_o,
  output logic                      skew_err_o
);

  logic all_valid;
  logic any_valid;
  logic any_q;
  logic mismatch;
  logic mismatch_q;

  assign all_valid = &al_valid_i;
  assign any_valid = |al_valid_i;
  assign mismatch  = any_valid && !all_valid;

  always_ff @(posedge px_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o    <= 1'b0;
      any_q      <= 1'b0;
      eob_o      <= 1'b0;
      mismatch_q <= 1'b0;
      skew_err_o <= 1'b0;
    end else begin
      valid_o    <= all_valid;
      any_q      <= any_valid;
      eob_o      <= any_q && !any_valid;
      mismatch_q <= mismatch;
      // One pulse per run of unmatched lane cycles
      skew_err_o <= mismatch && !mismatch_q;
    end
  end

  // Lane 0 lands in the low byte
  always_ff @(posedge px_clk_i) begin
    if (all_valid) begin
      word_o <= al_byte_i;
    end
  end

  a_eob_idle : assert property (
    @(posedge px_clk_i) disable iff (!rst_n_i) eob_o |-> !valid_o
  );

endmodule

`default_nettype wire

// File: design/csi2_pkt_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_pkt_decoder import csi2_pkg::*; (
  input  logic        px_clk_i,
  input  logic        rst_n_i,
  input  logic [15:0] word_i,
  input  logic        valid_i,
  input  logic        eob_i,
  output logic        wr_o,
  output logic [15:0] wr_data_o,
  output logic        wr_user_o,
  output logic        wr_last_o,
  output logic        header_err_o
);

  logic [1:0]   state_q;
  logic         hdr_half_q;
  logic [15:0]  hdr_lo_q;
  logic [14:0]  words_left_q;
  logic         fs_pending_q;
  csi2_header_u hdr;
  logic [7:0]   ecc_calc;
  logic         ecc_bad;

  function automatic logic [7:0] calc_ecc(input logic [23:0] data);
    logic [7:0] ecc;
    ecc = 8'h00;
    for (int i = 0; i < 6; i++) begin
      ecc[i] = ^(data & ECC_MASK[i]);
    end
    return ecc;
  endfunction

  // Second header word carries bytes 2 and 3
  assign hdr      = {word_i, hdr_lo_q};
  assign ecc_calc = calc_ecc(hdr.raw.data);
  assign ecc_bad  = ecc_calc != hdr.raw.ecc;

  always_ff @(posedge px_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= ST_HEADER;
      hdr_half_q   <= 1'b0;
      words_left_q <= '0;
      fs_pending_q <= 1'b0;
      wr_o         <= 1'b0;
      wr_user_o    <= 1'b0;
      wr_last_o    <= 1'b0;
      header_err_o <= 1'b0;
    end else begin
      wr_o         <= 1'b0;
      wr_last_o    <= 1'b0;
      header_err_o <= 1'b0;
      if (eob_i) begin
        state_q    <= ST_HEADER;
        hdr_half_q <= 1'b0;
      end else if (valid_i) begin
        case (state_q)
          ST_HEADER: begin
            hdr_half_q <= !hdr_half_q;
            if (hdr_half_q) begin
              if (ecc_bad) begin
                header_err_o <= 1'b1;
                state_q      <= ST_DISCARD;
              end else if (hdr.fields.dt == DT_FRAME_START) begin
                fs_pending_q <= 1'b1;
                state_q      <= ST_DISCARD;
              end else if (hdr.fields.dt >= DT_LONG_MIN && hdr.fields.wc[15:1] != 15'd0) begin
                words_left_q <= hdr.fields.wc[15:1];
                state_q      <= ST_PAYLOAD;
              end else begin
                // Frame end and other short packets carry no video
                state_q <= ST_DISCARD;
              end
            end
          end
          ST_PAYLOAD: begin
            wr_o         <= 1'b1;
            wr_user_o    <= fs_pending_q;
            fs_pending_q <= 1'b0;
            wr_last_o    <= words_left_q == 15'd1;
            words_left_q <= words_left_q - 15'd1;
            if (words_left_q == 15'd1) begin
              state_q <= ST_CRC;
            end
          end
          // CRC word is dropped unchecked
          ST_CRC: state_q <= ST_DISCARD;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge px_clk_i) begin
    // First header word holds bytes 0 and 1
    if (valid_i && state_q == ST_HEADER && !hdr_half_q) begin
      hdr_lo_q <= word_i;
    end
    if (valid_i && state_q == ST_PAYLOAD) begin
      wr_data_o <= word_i;
    end
  end

  a_last_with_wr : assert property (
    @(posedge px_clk_i) disable iff (!rst_n_i) wr_last_o |-> wr_o
  );

endmodule

`default_nettype wire

// File: design/csi2_video_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_video_fifo import csi2_pkg::*; (
  input  logic        px_clk_i,
  input  logic        rst_n_i,
  input  logic        wr_i,
  input  logic [15:0] wr_data_i,
  input  logic        wr_user_i,
  input  logic        wr_last_i,
  input  logic        tready_i,
  output logic [15:0] tdata_o,
  output logic        tvalid_o,
  output logic        tuser_o,
  output logic        tlast_o,
  output logic        overflow_o
);

  logic [17:0]        mem_q [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr_q;
  logic [FIFO_AW-1:0] rd_ptr_q;
  logic [FIFO_AW:0]   count_q;
  logic               full;
  logic               wr_en;
  logic               rd_en;

  assign full  = count_q == (FIFO_AW+1)'(FIFO_DEPTH);
  assign wr_en = wr_i && !full;
  assign rd_en = tvalid_o && tready_i;

  always_ff @(posedge px_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
      // Sticky until reset
      if (wr_i && full) begin
        overflow_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge px_clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= {wr_last_i, wr_user_i, wr_data_i};
    end
  end

  assign tvalid_o                     = count_q != '0;
  assign {tlast_o, tuser_o, tdata_o} = mem_q[rd_ptr_q];

  a_count_bound : assert property (
    @(posedge px_clk_i) disable iff (!rst_n_i) count_q <= (FIFO_AW+1)'(FIFO_DEPTH)
  );

endmodule

`default_nettype wire

// File: design/csi2_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_rx_top import csi2_pkg::*; (
  input  logic        px_clk_i,
  input  logic        rst_n_i,
  input  logic [7:0]  lane0_byte_i,
  input  logic [7:0]  lane1_byte_i,
  input  logic        lane0_valid_i,
  input  logic        lane1_valid_i,
  input  logic [1:0]  lane0_delay_i,
  input  logic [1:0]  lane1_delay_i,
  input  logic        video_tready_i,
  output logic [15:0] video_tdata_o,
  output logic        video_tvalid_o,
  output logic        video_tuser_o,
  output logic        video_tlast_o,
  output logic        header_err_o,
  output logic        skew_err_o,
  output logic        overflow_o
);

  logic [NUM_LANES-1:0][7:0] dsk_byte;
  logic [NUM_LANES-1:0]      dsk_valid;
  logic [NUM_LANES-1:0][7:0] al_byte;
  logic [NUM_LANES-1:0]      al_valid;
  logic [NUM_LANES-1:0]      al_locked;
  logic [15:0]               mg_word;
  logic                      mg_valid;
  logic                      mg_eob;
  logic                      fifo_wr;
  logic [15:0]               fifo_wr_data;
  logic                      fifo_wr_user;
  logic                      fifo_wr_last;

  csi2_lane_deskew u_deskew (
    .px_clk_i     ( px_clk_i                       ),
    .rst_n_i      ( rst_n_i                        ),
    .lane_byte_i  ( {lane1_byte_i, lane0_byte_i}   ),
    .lane_valid_i ( {lane1_valid_i, lane0_valid_i} ),
    .lane_delay_i ( {lane1_delay_i, lane0_delay_i} ),
    .dsk_byte_o   ( dsk_byte                       ),
    .dsk_valid_o  ( dsk_valid                      )
  );

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    csi2_lane_aligner u_aligner (
      .px_clk_i ( px_clk_i     ),
      .rst_n_i  ( rst_n_i      ),
      .byte_i   ( dsk_byte[g]  ),
      .valid_i  ( dsk_valid[g] ),
      .byte_o   ( al_byte[g]   ),
      .valid_o  ( al_valid[g]  ),
      .locked_o ( al_locked[g] )
    );
  end

  csi2_lane_merge u_merge (
    .px_clk_i   ( px_clk_i   ),
    .rst_n_i    ( rst_n_i    ),
    .al_byte_i  ( al_byte    ),
    .al_valid_i ( al_valid   ),
    .word_o     ( mg_word    ),
    .valid_o    ( mg_valid   ),
    .eob_o      ( mg_eob     ),
    .skew_err_o ( skew_err_o )
  );

  csi2_pkt_decoder u_decoder (
    .px_clk_i     ( px_clk_i     ),
    .rst_n_i      ( rst_n_i      ),
    .word_i       ( mg_word      ),
    .valid_i      ( mg_valid     ),
    .eob_i        ( mg_eob       ),
    .wr_o         ( fifo_wr      ),
    .wr_data_o    ( fifo_wr_data ),
    .wr_user_o    ( fifo_wr_user ),
    .wr_last_o    ( fifo_wr_last ),
    .header_err_o ( header_err_o )
  );

  csi2_video_fifo u_fifo (
    .px_clk_i   ( px_clk_i       ),
    .rst_n_i    ( rst_n_i        ),
    .wr_i       ( fifo_wr        ),
    .wr_data_i  ( fifo_wr_data   ),
    .wr_user_i  ( fifo_wr_user   ),
    .wr_last_i  ( fifo_wr_last   ),
    .tready_i   ( video_tready_i ),
    .tdata_o    ( video_tdata_o  ),
    .tvalid_o   ( video_tvalid_o ),
    .tuser_o    ( video_tuser_o  ),
    .tlast_o    ( video_tlast_o  ),
    .overflow_o ( overflow_o     )
  );

endmodule

`default_nettype wire

// File: test/csi2_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csi2_rx_tb import csi2_pkg::*; ;

  localparam int CLK_PERIOD     = 40;
  localparam int GAP_CYCLES     = 40;
  localparam int NUM_BURSTS     = 21;
  localparam int MAX_BURST      = 32;
  localparam int TIMEOUT_CYCLES = 4 * NUM_BURSTS * (MAX_BURST + GAP_CYCLES);
  localparam logic [5:0] DT_RAW8 = 6'h2A;

  logic        px_clk_i;
  logic        rst_n_i;
  logic [7:0]  lane0_byte_i;
  logic [7:0]  lane1_byte_i;
  logic        lane0_valid_i;
  logic        lane1_valid_i;
  logic [1:0]  lane0_delay_i;
  logic [1:0]  lane1_delay_i;
  logic        video_tready_i;
  logic [15:0] video_tdata_o;
  logic        video_tvalid_o;
  logic        video_tuser_o;
  logic        video_tlast_o;
  logic        header_err_o;
  logic        skew_err_o;
  logic        overflow_o;

  integer      seed = 77689;
  int          tready_mode = 2;
  int          hdr_err_seen = 0;
  int          skew_seen = 0;
  int          exp_hdr_err = 0;
  bit          ref_fs_pending = 1'b0;
  logic        ready_draw;
  logic [7:0]  pkt_q[$];
  logic [7:0]  enc_q[$];
  logic [7:0]  lane0_q[$];
  logic [7:0]  lane1_q[$];
  logic [17:0] exp_q[$];
  logic [17:0] exp_beat;

  csi2_rx_top u_csi2_rx_top (.*);

  always #(CLK_PERIOD / 2) px_clk_i = ~px_clk_i;

  task automatic report_failure(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  // CSI-2 Hamming table, entry i covers ECC bit i
  function automatic logic [7:0] header_ecc(input logic [23:0] data);
    logic [23:0] masks [6];
    logic [7:0]  ecc;
    masks[0] = 24'hF12CB7;
    masks[1] = 24'hF2555B;
    masks[2] = 24'h749A6D;
    masks[3] = 24'hB8E38E;
    masks[4] = 24'hDF03F0;
    masks[5] = 24'hEFFC00;
    ecc = 8'h00;
    for (int i = 0; i < 6; i++) begin
      ecc[i] = ^(data & masks[i]);
    end
    return ecc;
  endfunction

  task automatic build_packet(input logic [5:0] dt, input logic [15:0] wc, input bit bad_ecc);
    logic [23:0] hd;
    logic [7:0]  ecc;
    pkt_q.delete();
    hd  = {wc[15:8], wc[7:0], 2'b00, dt};
    ecc = header_ecc(hd);
    if (bad_ecc) begin
      ecc = ecc ^ 8'h04;
    end
    pkt_q.push_back(hd[7:0]);
    pkt_q.push_back(hd[15:8]);
    pkt_q.push_back(hd[23:16]);
    pkt_q.push_back(ecc);
    if (dt >= DT_LONG_MIN) begin
      // Payload then two CRC bytes
      for (int i = 0; i < int'(wc) + 2; i++) begin
        pkt_q.push_back(8'($random(seed)));
      end
    end
  endtask

  // Expected beats of the packet in pkt_q, cap models FIFO room
  function automatic void predict_beats(input int cap);
    logic [23:0] hd;
    logic [5:0]  dt;
    int          words;
    hd    = {pkt_q[2], pkt_q[1], pkt_q[0]};
    dt    = pkt_q[0][5:0];
    words = int'({pkt_q[2], pkt_q[1]}) / 2;
    if (header_ecc(hd) != pkt_q[3]) begin
      exp_hdr_err++;
    end else if (dt == DT_FRAME_START) begin
      ref_fs_pending = 1'b1;
    end else if (dt >= DT_LONG_MIN) begin
      for (int k = 0; k < words; k++) begin
        if (k < cap) begin
          exp_q.push_back({k == words - 1, ref_fs_pending, pkt_q[5 + 2 * k], pkt_q[4 + 2 * k]});
        end
        ref_fs_pending = 1'b0;
      end
    end
  endfunction

  // Even bytes to lane 0, odd to lane 1, leading zeros then sync
  task automatic encode_lane(input int lane, input int off);
    logic       bits[$];
    logic [7:0] b;
    enc_q.delete();
    repeat (off) bits.push_back(1'b0);
    for (int i = 0; i < 8; i++) begin
      bits.push_back(SYNC_BYTE[i]);
    end
    for (int j = lane; j < pkt_q.size(); j += 2) begin
      for (int i = 0; i < 8; i++) begin
        bits.push_back(pkt_q[j][i]);
      end
    end
    while (bits.size() % 8 != 0) begin
      bits.push_back(1'b0);
    end
    for (int n = 0; n < bits.size(); n += 8) begin
      for (int i = 0; i < 8; i++) begin
        b[i] = bits[n + i];
      end
      enc_q.push_back(b);
    end
  endtask

  task automatic send_burst(input int skew1);
    int len;
    int idx;
    encode_lane(0, $unsigned($random(seed)) % 8);
    lane0_q = enc_q;
    encode_lane(1, $unsigned($random(seed)) % 8);
    lane1_q = enc_q;
    len = lane0_q.size();
    if (lane1_q.size() + skew1 > len) begin
      len = lane1_q.size() + skew1;
    end
    for (int c = 0; c < len; c++) begin
      @(negedge px_clk_i);
      idx           = c - skew1;
      lane0_valid_i = c < lane0_q.size();
      lane0_byte_i  = (c < lane0_q.size()) ? lane0_q[c] : 8'h00;
      lane1_valid_i = idx >= 0 && idx < lane1_q.size();
      lane1_byte_i  = (idx >= 0 && idx < lane1_q.size()) ? lane1_q[idx] : 8'h00;
    end
    @(negedge px_clk_i);
    lane0_valid_i = 1'b0;
    lane1_valid_i = 1'b0;
    lane0_byte_i  = 8'h00;
    lane1_byte_i  = 8'h00;
    repeat (GAP_CYCLES) @(negedge px_clk_i);
  endtask

  task automatic run_packet(input logic [5:0] dt, input logic [15:0] wc, input bit bad_ecc,
                            input int skew1, input int cap);
    int skew_base;
    skew_base = skew_seen;
    build_packet(dt, wc, bad_ecc);
    predict_beats(cap);
    send_burst(skew1);
    assert (hdr_err_seen == exp_hdr_err)
      else report_failure($sformatf("header_err pulses %0d, expected %0d",
                                    hdr_err_seen, exp_hdr_err));
    if (skew1 == int'(lane0_delay_i)) begin
      assert (skew_seen == skew_base) else report_failure("unexpected skew_err pulse");
    end else begin
      assert (skew_seen > skew_base) else report_failure("missing skew_err pulse");
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(negedge px_clk_i);
    end
  endtask

  function automatic logic [15:0] random_wc();
    return 16'(2 * (1 + $unsigned($random(seed)) % 12));
  endfunction

  always @(posedge px_clk_i) begin
    ready_draw = ($random(seed) & 3) != 0;
  end

  always @(negedge px_clk_i) begin
    case (tready_mode)
      0:       video_tready_i = ready_draw;
      1:       video_tready_i = 1'b0;
      default: video_tready_i = 1'b1;
    endcase
  end

  always @(posedge px_clk_i) begin
    if (header_err_o) hdr_err_seen++;
    if (skew_err_o) skew_seen++;
  end

  // Beat comparator
  always @(posedge px_clk_i) begin
    if (rst_n_i && video_tvalid_o && video_tready_i) begin
      assert (exp_q.size() != 0) else report_failure("beat accepted with none expected");
      exp_beat = exp_q.pop_front();
      assert ({video_tlast_o, video_tuser_o, video_tdata_o} == exp_beat)
        else report_failure($sformatf("beat last/user/data %0b/%0b/%h, expected %0b/%0b/%h",
                                      video_tlast_o, video_tuser_o, video_tdata_o,
                                      exp_beat[17], exp_beat[16], exp_beat[15:0]));
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Testbench failed");
    $fatal(1);
  end

  initial begin
    px_clk_i       = 1'b0;
    rst_n_i        = 1'b0;
    lane0_byte_i   = 8'h00;
    lane1_byte_i   = 8'h00;
    lane0_valid_i  = 1'b0;
    lane1_valid_i  = 1'b0;
    lane0_delay_i  = 2'd0;
    lane1_delay_i  = 2'd0;
    video_tready_i = 1'b0;
    repeat (16) @(posedge px_clk_i);
    @(negedge px_clk_i);
    rst_n_i = 1'b1;
    @(negedge px_clk_i);
    assert (!video_tvalid_o && !header_err_o && !skew_err_o && !overflow_o)
      else report_failure("outputs not idle after reset");

    // Frame start then long packets at random offsets
    run_packet(DT_FRAME_START, 16'd0, 1'b0, 0, 1000);
    for (int i = 0; i < 8; i++) begin
      run_packet(DT_RAW8, random_wc(), 1'b0, 0, 1000);
    end
    wait_drain();

    // Corrupted ECC then a good packet
    run_packet(DT_RAW8, 16'd8, 1'b1, 0, 1000);
    run_packet(DT_RAW8, 16'd10, 1'b0, 0, 1000);
    wait_drain();

    // Lane 1 late by two cycles, compensated and then not
    lane0_delay_i = 2'd2;
    run_packet(DT_RAW8, 16'd12, 1'b0, 2, 1000);
    wait_drain();
    lane0_delay_i = 2'd0;
    run_packet(DT_FRAME_END, 16'd0, 1'b0, 2, 1000);

    tready_mode = 0;
    run_packet(DT_FRAME_START, 16'd0, 1'b0, 0, 1000);
    for (int i = 0; i < 6; i++) begin
      run_packet(DT_RAW8, random_wc(), 1'b0, 0, 1000);
    end
    wait_drain();
    assert (!overflow_o) else report_failure("overflow_o set under random tready");

    // Twenty words into a stalled 16-entry FIFO
    tready_mode = 1;
    run_packet(DT_RAW8, 16'd40, 1'b0, 0, FIFO_DEPTH);
    assert (overflow_o) else report_failure("overflow_o not set on a full FIFO");
    tready_mode = 2;
    wait_drain();
    repeat (4) @(posedge px_clk_i);

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: csi2_rx_lite.f
design/csi2_pkg.sv
design/csi2_lane_deskew.sv
design/csi2_lane_aligner.sv
design/csi2_lane_merge.sv
design/csi2_pkt_decoder.sv
design/csi2_video_fifo.sv
design/csi2_rx_top.sv
test/csi2_rx_tb.sv

// File: run.sh
#!/bin/sh
# Builds and runs the CSI-2 receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module csi2_rx_tb \
  -f csi2_rx_lite.f \
  -o csi2_rx_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/csi2_rx_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Testbench passed"; then
  exit 0
fi
exit 1
